// ==== include/cmdseq_macros.svh ====
/*
 * Sizing and bus address constants for the command sequencer.
 * Include this header in any file that needs channel count, queue depth,
 * field widths or programming bus addresses.
 */
`ifndef CMDSEQ_MACROS_SVH
`define CMDSEQ_MACROS_SVH

// channel layout
`define CMDSEQ_NCHAN        4         // sensor channels, one queue each
`define CMDSEQ_QDEPTH       4         // entries per channel queue, power of two

// field widths
`define CMDSEQ_WADDR_BITS   12        // downstream write address
`define CMDSEQ_FRAME_BITS   4         // frame counter and command tag

// programming bus map
`define CMDSEQ_CMD_BASE     16'h0700  // channel n commands at base + n
`define CMDSEQ_STATUS_CTRL  16'h0704  // status mode and sequence byte

// status packet
`define CMDSEQ_STATUS_ADDR  8'h38     // first byte sent with status_rq

`endif

// ==== src/cmdseq_pkg.sv ====
/*
 * Shared types of the command sequencer: queued writes, channel commands,
 * the merged output write and the status payload.
 * Compile before any module of the design or the testbench.
 */
`include "cmdseq_macros.svh"

package cmdseq_pkg;

    localparam int CHAN_BITS = $clog2(`CMDSEQ_NCHAN); // channel index width

    // one queued write, channel implied by the queue holding it
    typedef struct packed {
        logic [`CMDSEQ_WADDR_BITS-1:0] waddr;  // downstream register address
        logic [31:0]                   wdata;  // register data
        logic [`CMDSEQ_FRAME_BITS-1:0] frame;  // release when counter matches
    } seq_write_t;

    typedef struct packed {
        logic [CHAN_BITS-1:0] chan;  // target queue
        seq_write_t           cmd;
    } chan_cmd_t;

    typedef struct packed {
        logic [CHAN_BITS-1:0]          chan;   // source channel of the write
        logic [`CMDSEQ_WADDR_BITS-1:0] waddr;
        logic [31:0]                   wdata;
    } out_write_t;

    // 18-bit status payload, channel 3 frame number in the top nibble
    typedef struct packed {
        logic [`CMDSEQ_NCHAN-1:0][`CMDSEQ_FRAME_BITS-1:0] frame_num;
        logic                                             overflow;  // any queue dropped
        logic                                             rsvd;      // always zero
    } status_word_t;

endpackage

// ==== src/cmd_deser.sv ====
/*
 * Byte-serial programming bus receiver. Collects address low/high and the
 * payload bytes, then emits either a channel command or a status-control
 * byte as a single-cycle pulse one cycle after the last byte.
 */
`timescale 1ns/1ps
`include "cmdseq_macros.svh"

module cmd_deser (
    input  logic                  mclk,
    input  logic                  mrst,
    input  logic [7:0]            cmd_ad,     // address/data byte
    input  logic                  cmd_stb,    // with the first (address low) byte
    output logic                  cmd_valid,  // channel command pulse
    output cmdseq_pkg::chan_cmd_t cmd,
    output logic                  stat_we,    // status-control pulse
    output logic [7:0]            stat_wd
);
    import cmdseq_pkg::*;

    logic                 busy;       // inside a packet
    logic [2:0]           bcnt;       // index of the byte on cmd_ad
    logic [2:0]           last_idx;   // 7 for commands, 2 otherwise
    logic                 is_cmd_r;   // packet targets a channel queue
    logic                 is_stat_r;  // packet targets status control
    logic [7:0]           addr_lo;
    logic [CHAN_BITS-1:0] chan_r;
    logic [39:0]          sr;         // W0..D2, oldest byte lowest
    logic [15:0]          full_addr;
    logic                 hit_cmd;
    logic                 hit_stat;
    logic                 last_byte;

    assign full_addr = {cmd_ad, addr_lo};  // valid while bcnt == 1
    assign hit_cmd   = (full_addr >= `CMDSEQ_CMD_BASE) &&
                       (full_addr < (`CMDSEQ_CMD_BASE + 16'(`CMDSEQ_NCHAN)));
    assign hit_stat  = full_addr == `CMDSEQ_STATUS_CTRL;
    assign last_byte = busy && (bcnt != 3'd1) && (bcnt == last_idx);

    always_ff @(posedge mclk) begin
        if (mrst) begin
            busy      <= 1'b0;
            bcnt      <= 3'd0;
            last_idx  <= 3'd2;
            is_cmd_r  <= 1'b0;
            is_stat_r <= 1'b0;
            cmd_valid <= 1'b0;
            stat_we   <= 1'b0;
        end else begin
            cmd_valid <= last_byte && is_cmd_r;
            stat_we   <= last_byte && is_stat_r;
            if (cmd_stb) begin
                busy <= 1'b1;
                bcnt <= 3'd1;                        // address high comes next
            end else if (last_byte) begin
                busy <= 1'b0;
                bcnt <= 3'd0;
            end else if (busy) begin
                bcnt <= bcnt + 3'd1;
                if (bcnt == 3'd1) begin              // address complete, decode it
                    is_cmd_r  <= hit_cmd;
                    is_stat_r <= hit_stat;
                    last_idx  <= hit_cmd ? 3'd7 : 3'd2;  // unknown skips one byte
                end
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (cmd_stb) addr_lo <= cmd_ad;
        if (busy && bcnt == 3'd1) chan_r <= CHAN_BITS'(full_addr - `CMDSEQ_CMD_BASE);
        if (busy && bcnt != 3'd1) sr <= {cmd_ad, sr[39:8]};
        if (last_byte) begin
            cmd.chan      <= chan_r;
            cmd.cmd.waddr <= sr[11:0];            // W1 low nibble over W0
            cmd.cmd.frame <= sr[15:12];           // W1 high nibble
            cmd.cmd.wdata <= {cmd_ad, sr[39:16]}; // D3 arrives last
            stat_wd       <= cmd_ad;              // only byte of status writes
        end
    end

    // a new packet may only start once the previous one is complete
    a_no_stb_in_packet: assert property (@(posedge mclk) disable iff (mrst)
        busy |-> !cmd_stb)
        else $error("cmd_stb inside a packet");

endmodule

// ==== src/chan_cmd_queue.sv ====
/*
 * Per-channel frame counter and command queue. Accepts commands addressed
 * to CHAN, holds the head until the frame counter reaches its tag and then
 * requests the mux. Commands for a full queue are dropped and flagged.
 */
`timescale 1ns/1ps
`include "cmdseq_macros.svh"

module chan_cmd_queue #(
    parameter int CHAN = 0  // channel index accepted by this queue
) (
    input  logic                          mclk,
    input  logic                          mrst,
    input  logic                          frame_sync,  // start of a sensor frame
    input  logic                          cmd_valid,
    input  cmdseq_pkg::chan_cmd_t         cmd,
    input  logic                          ackn,        // head taken by the mux
    output logic                          rd_req,      // head is due
    output cmdseq_pkg::seq_write_t        head,
    output logic [`CMDSEQ_FRAME_BITS-1:0] frame_num,
    output logic                          overflow     // sticky drop flag
);
    import cmdseq_pkg::*;

    localparam int PTR_BITS = $clog2(`CMDSEQ_QDEPTH);

    seq_write_t        mem [`CMDSEQ_QDEPTH];
    logic [PTR_BITS:0] wr_ptr;      // extra msb tells full from empty
    logic [PTR_BITS:0] rd_ptr;
    logic [PTR_BITS:0] rd_ptr_nxt;  // read pointer after this cycle's pop
    logic              match;
    logic              push;
    logic              empty;
    logic              full;
    logic              empty_nxt;

    assign match      = cmd_valid && (cmd.chan == CHAN_BITS'(CHAN));
    assign empty      = wr_ptr == rd_ptr;
    assign full       = (wr_ptr[PTR_BITS] != rd_ptr[PTR_BITS]) &&
                        (wr_ptr[PTR_BITS-1:0] == rd_ptr[PTR_BITS-1:0]);
    assign push       = match && !full;
    assign rd_ptr_nxt = rd_ptr + (PTR_BITS + 1)'(ackn);
    assign empty_nxt  = wr_ptr == rd_ptr_nxt;  // same-cycle push shows up next cycle
    assign head       = mem[rd_ptr[PTR_BITS-1:0]];

    always_ff @(posedge mclk) begin
        if (push) mem[wr_ptr[PTR_BITS-1:0]] <= cmd.cmd;
    end

    always_ff @(posedge mclk) begin
        if (mrst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            frame_num <= '0;
            overflow  <= 1'b0;
            rd_req    <= 1'b0;
        end else begin
            if (frame_sync) frame_num <= frame_num + 1'b1;  // wraps with the tag
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (match && full) overflow <= 1'b1;             // command lost
            rd_ptr <= rd_ptr_nxt;
            // look past the pop so the next head is not requested with stale state
            rd_req <= !empty_nxt &&
                      (mem[rd_ptr_nxt[PTR_BITS-1:0]].frame == frame_num);
        end
    end

    // the mux acknowledges only a request it saw on the previous cycle
    a_ackn_after_req: assert property (@(posedge mclk) disable iff (mrst)
        ackn |-> $past(rd_req))
        else $error("channel %0d: ackn without request", CHAN);

    a_no_pop_empty: assert property (@(posedge mclk) disable iff (mrst)
        ackn |-> !empty)
        else $error("channel %0d: pop from empty queue", CHAN);

endmodule

// ==== src/cmd_seq_mux.sv ====
/*
 * Round-robin merge of the channel queues into one registered write port.
 * The search starts after the last channel served; a grant loads the head
 * into the output register and acknowledges the queue on the next cycle.
 */
`timescale 1ns/1ps
`include "cmdseq_macros.svh"

module cmd_seq_mux (
    input  logic                                          mclk,
    input  logic                                          mrst,
    input  logic                   [`CMDSEQ_NCHAN-1:0]    rd_req,
    input  cmdseq_pkg::seq_write_t [`CMDSEQ_NCHAN-1:0]    heads,
    input  logic                                          ackn_out,   // downstream took wr_out
    output logic                   [`CMDSEQ_NCHAN-1:0]    ackn,       // pop pulse per queue
    output logic                                          wr_en_out,  // output register full
    output cmdseq_pkg::out_write_t                        wr_out
);
    import cmdseq_pkg::*;

    localparam int NCH = `CMDSEQ_NCHAN;

    logic [NCH-1:0]       req;       // requests not already being popped
    logic [CHAN_BITS-1:0] last_r;    // last channel served
    logic [CHAN_BITS-1:0] sel;
    logic                 found;
    logic                 grant;
    seq_write_t           sel_head;

    assign req = rd_req & ~ackn;  // registered ackn lags the pop by a cycle

    always_comb begin
        logic [CHAN_BITS-1:0] idx;
        sel   = last_r;
        found = 1'b0;
        for (int i = 1; i <= NCH; i++) begin
            idx = last_r + CHAN_BITS'(i);  // wraps so the last served is checked last
            if (!found && req[idx]) begin
                sel   = idx;
                found = 1'b1;
            end
        end
    end

    assign grant    = found && (!wr_en_out || ackn_out);  // slot free or freeing now
    assign sel_head = heads[sel];

    always_ff @(posedge mclk) begin
        if (mrst) begin
            wr_en_out <= 1'b0;
            ackn      <= '0;
            last_r    <= CHAN_BITS'(NCH - 1);  // first search starts at channel 0
        end else begin
            ackn <= grant ? (NCH'(1) << sel) : '0;
            if (grant) begin
                wr_en_out <= 1'b1;
                last_r    <= sel;
            end else if (ackn_out) begin
                wr_en_out <= 1'b0;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (grant) begin
            wr_out.chan  <= sel;
            wr_out.waddr <= sel_head.waddr;
            wr_out.wdata <= sel_head.wdata;
        end
    end

    a_ackn_onehot: assert property (@(posedge mclk) disable iff (mrst)
        $onehot0(ackn))
        else $error("more than one queue acknowledged");

endmodule

// ==== src/status_generate.sv ====
/*
 * Status packet source. A control byte sets the mode (off, send once, send
 * on change) and a sequence number; the packet is the address byte held
 * with status_rq, then three payload bytes after status_start.
 */
`timescale 1ns/1ps
`include "cmdseq_macros.svh"

module status_generate (
    input  logic                       mclk,
    input  logic                       mrst,
    input  logic                       we,            // control byte strobe
    input  logic [7:0]                 wd,            // {seq[5:0], mode[1:0]}
    input  cmdseq_pkg::status_word_t   status,
    input  logic                       status_start,  // address byte accepted
    output logic [7:0]                 status_ad,
    output logic                       status_rq
);
    import cmdseq_pkg::*;

    logic [1:0]   mode;
    logic [5:0]   seq;        // echoed in the first payload byte
    logic         send_once;  // single-shot request pending
    logic [1:0]   bcnt;       // payload byte on status_ad, 0 when idle
    logic         changed;
    status_word_t last_sent;
    status_word_t snap;       // payload frozen at status_start

    assign changed = (mode == 2'd2) && (status != last_sent);

    always_ff @(posedge mclk) begin
        if (mrst) begin
            mode      <= 2'd0;
            seq       <= '0;
            send_once <= 1'b0;
            bcnt      <= 2'd0;
            status_rq <= 1'b0;
            last_sent <= '0;
        end else begin
            if (we) begin
                mode      <= wd[1:0];
                seq       <= wd[7:2];
                send_once <= wd[1:0] == 2'd1;
            end else if (status_start) begin
                send_once <= 1'b0;
            end
            if (status_start) begin
                status_rq <= 1'b0;
                bcnt      <= 2'd1;
                last_sent <= status;             // auto mode compares against this
            end else if (bcnt != 2'd0) begin
                bcnt <= bcnt + 2'd1;             // 3 wraps to idle
            end else if (!status_rq && (send_once || changed)) begin
                status_rq <= 1'b1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (status_start) snap <= status;
    end

    always_comb begin
        case (bcnt)
            2'd1:    status_ad = {seq, snap[1:0]};
            2'd2:    status_ad = snap[9:2];
            2'd3:    status_ad = snap[17:10];
            default: status_ad = status_rq ? `CMDSEQ_STATUS_ADDR : 8'h00;
        endcase
    end

    // the receiver may only start a packet that was requested
    a_start_with_rq: assert property (@(posedge mclk) disable iff (mrst)
        status_start |-> status_rq)
        else $error("status_start without status_rq");

endmodule

// ==== src/cmd_seq_top.sv ====
/*
 * Command sequencer subsystem top: bus receiver, one frame-tagged queue
 * per sensor channel, the round-robin write mux and the status packet
 * source carrying frame numbers and the overflow flag.
 */
`timescale 1ns/1ps
`include "cmdseq_macros.svh"

module cmd_seq_top (
    input  logic                           mclk,
    input  logic                           mrst,
    input  logic [7:0]                     cmd_ad,
    input  logic                           cmd_stb,
    input  logic [`CMDSEQ_NCHAN-1:0]       frame_sync,    // one pulse per channel frame
    input  logic                           ackn_out,
    input  logic                           status_start,
    output logic                           wr_en_out,
    output cmdseq_pkg::out_write_t         wr_out,
    output logic [7:0]                     status_ad,
    output logic                           status_rq
);
    import cmdseq_pkg::*;

    logic                                              cmd_valid;
    chan_cmd_t                                         cmd;        // shared by all queues
    logic                                              stat_we;
    logic [7:0]                                        stat_wd;
    logic [`CMDSEQ_NCHAN-1:0]                          rd_req;
    logic [`CMDSEQ_NCHAN-1:0]                          ackn;
    logic [`CMDSEQ_NCHAN-1:0]                          overflow;
    seq_write_t [`CMDSEQ_NCHAN-1:0]                    heads;
    logic [`CMDSEQ_NCHAN-1:0][`CMDSEQ_FRAME_BITS-1:0]  frame_num;
    status_word_t                                      status;

    cmd_deser cmd_deser_i (
        .mclk      (mclk),
        .mrst      (mrst),
        .cmd_ad    (cmd_ad),
        .cmd_stb   (cmd_stb),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .stat_we   (stat_we),
        .stat_wd   (stat_wd)
    );

    for (genvar i = 0; i < `CMDSEQ_NCHAN; i++) begin : gen_chan
        chan_cmd_queue #(
            .CHAN (i)
        ) chan_cmd_queue_i (
            .mclk       (mclk),
            .mrst       (mrst),
            .frame_sync (frame_sync[i]),
            .cmd_valid  (cmd_valid),
            .cmd        (cmd),
            .ackn       (ackn[i]),
            .rd_req     (rd_req[i]),
            .head       (heads[i]),
            .frame_num  (frame_num[i]),
            .overflow   (overflow[i])
        );
    end

    cmd_seq_mux cmd_seq_mux_i (
        .mclk      (mclk),
        .mrst      (mrst),
        .rd_req    (rd_req),
        .heads     (heads),
        .ackn_out  (ackn_out),
        .ackn      (ackn),
        .wr_en_out (wr_en_out),
        .wr_out    (wr_out)
    );

    assign status = '{frame_num: frame_num, overflow: |overflow, rsvd: 1'b0};

    status_generate status_generate_i (
        .mclk         (mclk),
        .mrst         (mrst),
        .we           (stat_we),
        .wd           (stat_wd),
        .status       (status),
        .status_start (status_start),
        .status_ad    (status_ad),
        .status_rq    (status_rq)
    );

endmodule

// ==== dv/cmd_seq_tb.sv ====
/*
 * Directed testbench for the command sequencer top. Drives the programming
 * bus, frame pulses and the status handshake, models the downstream write
 * port and checks every write and status packet against predicted values.
 */
`timescale 1ns/1ps
`include "cmdseq_macros.svh"

module cmd_seq_tb;
    import cmdseq_pkg::*;

    localparam int NCH            = `CMDSEQ_NCHAN;
    localparam int TIMEOUT_CYCLES = 4000;  // six tests of a few hundred cycles at most

    logic                          mclk = 1'b0;
    logic                          mrst;
    logic [7:0]                    cmd_ad;
    logic                          cmd_stb;
    logic [NCH-1:0]                frame_sync;
    logic                          ackn_out;
    logic                          status_start;
    logic                          wr_en_out;
    out_write_t                    wr_out;
    logic [7:0]                    status_ad;
    logic                          status_rq;

    logic [31:0]                   rng_state = 32'h7390;
    int                            cycle_cnt = 0;
    int                            last_served;       // model of the mux pointer
    logic [`CMDSEQ_FRAME_BITS-1:0] frame_cnt [NCH];   // expected frame counters
    logic                          ovf_exp;
    out_write_t                    sent_q [$];        // written, not yet due
    out_write_t                    expect_q [$];      // predicted wr_out order
    out_write_t                    got_q [$];         // taken by downstream
    logic                          stall = 1'b0;      // downstream holds ackn_out low
    int                            ack_delay = 0;     // cycles before each ackn_out

    cmd_seq_top cmd_seq_top_i (
        .mclk         (mclk),
        .mrst         (mrst),
        .cmd_ad       (cmd_ad),
        .cmd_stb      (cmd_stb),
        .frame_sync   (frame_sync),
        .ackn_out     (ackn_out),
        .status_start (status_start),
        .wr_en_out    (wr_en_out),
        .wr_out       (wr_out),
        .status_ad    (status_ad),
        .status_rq    (status_rq)
    );

    always #4 mclk = ~mclk;  // 8 ns period

    always @(posedge mclk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            stop_with_error($sformatf("timeout, run exceeded %0d cycles", TIMEOUT_CYCLES));
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_write(input string name, input out_write_t exp, input out_write_t got);
        if (got !== exp)
            stop_with_error($sformatf("Mismatch at %0t: %s expected %h got %h",
                                      $time, name, exp, got));
    endtask

    task automatic check_status(input status_word_t exp, input logic [5:0] exp_seq,
                                input status_word_t got, input logic [5:0] got_seq);
        if (got !== exp || got_seq !== exp_seq)
            stop_with_error($sformatf(
                "Mismatch at %0t: status packet expected seq %h payload %h got seq %h payload %h",
                $time, exp_seq, exp, got_seq, got));
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp)
            stop_with_error($sformatf("Mismatch at %0t: %s expected %h got %h",
                                      $time, name, exp, got));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp)
            stop_with_error($sformatf("Mismatch at %0t: %s expected %b got %b",
                                      $time, name, exp, got));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r         = rng_state;
    endtask

    task automatic next_cycle();
        @(posedge mclk);
        #1;  // inputs change away from the edge
    endtask

    // downstream port acks after ack_delay cycles unless stalled
    initial begin : downstream_model
        logic       held_valid;
        out_write_t held_wr;
        int         wait_n;
        held_valid = 1'b0;
        wait_n     = 0;
        ackn_out   = 1'b0;
        forever begin
            next_cycle();
            if (held_valid) begin                     // unacked write must not move
                if (!wr_en_out)
                    stop_with_error("wr_en_out dropped before ackn_out");
                check_write("wr_out", held_wr, wr_out);
            end
            ackn_out   = wr_en_out && !stall && (wait_n >= ack_delay);
            held_valid = wr_en_out && !ackn_out;
            held_wr    = wr_out;
            if (ackn_out) begin
                got_q.push_back(wr_out);              // taken on the next edge
                wait_n = 0;
            end else if (wr_en_out) begin
                wait_n++;
            end else begin
                wait_n = 0;
            end
        end
    end

    task automatic apply_reset();
        next_cycle();
        mrst = 1'b1;
        repeat (4) next_cycle();
        mrst = 1'b0;
        sent_q.delete();
        expect_q.delete();
        got_q.delete();
        last_served = NCH - 1;                        // first search starts at channel 0
        ovf_exp     = 1'b0;
        for (int i = 0; i < NCH; i++)
            frame_cnt[i] = '0;
    endtask

    task automatic set_downstream(input logic hold, input int delay);
        @(negedge mclk);                              // away from the model's update
        stall     = hold;
        ack_delay = delay;
    endtask

    task automatic send_byte(input logic [7:0] b, input logic first);
        next_cycle();
        cmd_ad  = b;
        cmd_stb = first;
    endtask

    task automatic bus_idle();
        next_cycle();
        cmd_ad  = 8'h00;
        cmd_stb = 1'b0;
    endtask

    // random address and data tagged for a frame
    task automatic write_command(input int chan, input logic [`CMDSEQ_FRAME_BITS-1:0] tag);
        logic [31:0] r;
        logic [31:0] wdata;
        logic [15:0] addr;
        out_write_t  w;
        next_rand(r);
        next_rand(wdata);
        addr = `CMDSEQ_CMD_BASE + 16'(chan);
        send_byte(addr[7:0], 1'b1);
        send_byte(addr[15:8], 1'b0);
        send_byte(r[7:0], 1'b0);                      // W0
        send_byte({tag, r[11:8]}, 1'b0);              // W1
        for (int i = 0; i < 4; i++)
            send_byte(wdata[8*i +: 8], 1'b0);         // D0 first
        bus_idle();
        w.chan  = CHAN_BITS'(chan);
        w.waddr = r[11:0];
        w.wdata = wdata;
        sent_q.push_back(w);
    endtask

    task automatic write_status_ctrl(input logic [5:0] seq, input logic [1:0] mode);
        logic [15:0] addr;
        addr = `CMDSEQ_STATUS_CTRL;
        send_byte(addr[7:0], 1'b1);
        send_byte(addr[15:8], 1'b0);
        send_byte({seq, mode}, 1'b0);
        bus_idle();
    endtask

    task automatic frame_pulse(input logic [NCH-1:0] mask);
        next_cycle();
        frame_sync = mask;
        next_cycle();
        frame_sync = '0;
        for (int i = 0; i < NCH; i++)
            if (mask[i])
                frame_cnt[i] = frame_cnt[i] + 1'b1;
    endtask

    // round robin over due channels with the oldest command of a channel first
    task automatic predict_release(input logic [NCH-1:0] mask);
        int pick;
        int ch;
        pick = 0;
        while (pick >= 0) begin
            pick = -1;
            for (int k = 1; k <= NCH && pick < 0; k++) begin
                ch = (last_served + k) % NCH;
                for (int j = 0; j < sent_q.size() && mask[ch] && pick < 0; j++)
                    if (sent_q[j].chan == ch)
                        pick = j;
            end
            if (pick >= 0) begin
                expect_q.push_back(sent_q[pick]);
                last_served = ch;
                sent_q.delete(pick);
            end
        end
    endtask

    task automatic collect_writes(input int limit);
        int n;
        int waited;
        n      = expect_q.size();
        waited = 0;
        while (got_q.size() < n) begin
            if (waited == limit)
                stop_with_error($sformatf("only %0d of %0d writes arrived within %0d cycles",
                                          got_q.size(), n, limit));
            @(negedge mclk);
            waited++;
        end
        while (expect_q.size() > 0)
            check_write("wr_out", expect_q.pop_front(), got_q.pop_front());
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) @(negedge mclk);
        if (got_q.size() != 0)
            stop_with_error($sformatf("%0d unexpected writes on wr_out", got_q.size()));
        check_flag("wr_en_out", 1'b0, wr_en_out);
    endtask

    task automatic read_status(input logic [5:0] seq, input int max_wait);
        status_word_t exp;
        status_word_t got;
        logic [7:0]   b0;
        logic [7:0]   b1;
        logic [7:0]   b2;
        int           waited;
        waited = 0;
        next_cycle();
        while (!status_rq) begin
            if (waited == max_wait)
                stop_with_error("status_rq did not rise for an expected packet");
            next_cycle();
            waited++;
        end
        check_byte("status_ad", `CMDSEQ_STATUS_ADDR, status_ad);
        status_start = 1'b1;
        next_cycle();
        status_start = 1'b0;
        check_flag("status_rq", 1'b0, status_rq);
        b0 = status_ad;                               // seq and payload 1:0
        next_cycle();
        b1 = status_ad;
        next_cycle();
        b2 = status_ad;
        for (int i = 0; i < NCH; i++)
            exp.frame_num[i] = frame_cnt[i];
        exp.overflow = ovf_exp;
        exp.rsvd     = 1'b0;
        got          = {b2, b1, b0[1:0]};
        check_status(exp, seq, got, b0[7:2]);
    endtask

    task automatic check_no_status(input int cycles);
        repeat (cycles) begin
            next_cycle();
            check_flag("status_rq", 1'b0, status_rq);
        end
    endtask

    task automatic single_write_test();
        apply_reset();
        set_downstream(1'b0, 3);                      // ackn_out after 3 waiting cycles
        write_command(2, 4'd0);
        predict_release(4'b0100);
        collect_writes(40);
        check_quiet(6);
    endtask

    task automatic frame_tag_test();
        apply_reset();
        set_downstream(1'b0, 0);
        write_command(1, 4'd3);
        write_command(0, 4'd0);
        predict_release(4'b0001);                     // channel 0 overtakes
        collect_writes(40);
        frame_pulse(4'b0010);
        frame_pulse(4'b0010);
        check_quiet(10);                              // frame 2 still held
        frame_pulse(4'b0010);
        predict_release(4'b0010);
        collect_writes(20);
        check_quiet(6);
    endtask

    task automatic round_robin_test();
        apply_reset();
        set_downstream(1'b0, 0);                      // ack every cycle
        write_command(2, 4'd1);
        write_command(1, 4'd1);
        write_command(3, 4'd1);
        write_command(0, 4'd1);
        write_command(1, 4'd1);
        frame_pulse(4'b1111);                         // all heads due together
        predict_release(4'b1111);
        collect_writes(40);
        write_command(0, 4'd2);
        write_command(3, 4'd2);
        write_command(1, 4'd2);
        frame_pulse(4'b1111);                         // search resumes after channel 1
        predict_release(4'b1111);
        collect_writes(40);
        check_quiet(6);
    endtask

    task automatic back_pressure_test();
        int waited;
        waited = 0;
        apply_reset();
        set_downstream(1'b1, 0);
        write_command(3, 4'd1);
        write_command(1, 4'd1);
        write_command(2, 4'd1);
        write_command(3, 4'd1);
        frame_pulse(4'b1111);
        predict_release(4'b1111);
        while (!wr_en_out) begin
            if (waited == 10)
                stop_with_error("wr_en_out did not rise after the frame pulse");
            @(negedge mclk);
            waited++;
        end
        repeat (20) begin                             // output register must hold
            @(negedge mclk);
            check_flag("wr_en_out", 1'b1, wr_en_out);
            check_write("wr_out", expect_q[0], wr_out);
        end
        set_downstream(1'b0, 0);
        collect_writes(40);
        check_quiet(6);
    endtask

    task automatic status_packet_test();
        apply_reset();
        frame_pulse(4'b0100);
        frame_pulse(4'b0101);
        write_status_ctrl(6'h15, 2'd1);               // send once
        read_status(6'h15, 8);
        check_no_status(10);
        write_status_ctrl(6'h2a, 2'd2);               // send on change
        check_no_status(6);                           // payload unchanged yet
        frame_pulse(4'b1000);
        read_status(6'h2a, 2);
        frame_pulse(4'b1000);
        read_status(6'h2a, 2);
        write_status_ctrl(6'h00, 2'd0);
        frame_pulse(4'b0001);
        check_no_status(6);
    endtask

    task automatic overflow_test();
        apply_reset();
        set_downstream(1'b0, 0);
        for (int i = 0; i <= `CMDSEQ_QDEPTH; i++)
            write_command(2, 4'd5);
        sent_q.delete(sent_q.size() - 1);             // last one hits a full queue
        ovf_exp = 1'b1;
        write_status_ctrl(6'h3c, 2'd1);
        read_status(6'h3c, 8);
        repeat (5) frame_pulse(4'b0100);
        predict_release(4'b0100);
        collect_writes(40);
        check_quiet(10);
    endtask

    initial begin
        mrst         = 1'b1;
        cmd_ad       = 8'h00;
        cmd_stb      = 1'b0;
        frame_sync   = '0;
        status_start = 1'b0;
        single_write_test();
        frame_tag_test();
        round_robin_test();
        back_pressure_test();
        status_packet_test();
        overflow_test();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
src/cmdseq_pkg.sv
src/cmd_deser.sv
src/chan_cmd_queue.sv
src/cmd_seq_mux.sv
src/status_generate.sv
src/cmd_seq_top.sv
dv/cmd_seq_tb.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the command sequencer
TOP = cmd_seq_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module cmd_seq_top

clean:
	rm -rf obj_dir
